// ==== Bender.yml ====
package:
  name: dcache_ctrl

sources:
  - files:
      - hdl/dcache_pkg.sv
      - hdl/miss_sequencer.sv
      - hdl/beat_issuer.sv
      - hdl/line_assembler.sv
      - hdl/dcache_ctrl.sv
  - target: test
    files:
      - testbench/bus_responder.sv
      - testbench/tb_dcache_ctrl.sv

// ==== hdl/beat_issuer.sv ====
// ====================================================================
// Beat issuer: pending beat slots, one bus cycle at a time,
// LFSR-randomized backoff after a retry
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module beat_issuer #(
	parameter int BACKOFF = 6,
	localparam int CNT_W = $clog2(BACKOFF + 1)
) (
	input  logic                                clk_i,
	input  logic                                rst_i,
	// Beat plan from the sequencer
	input  logic                                start_i,
	input  logic [dcache_pkg::BEATS-1:0]        beat_mask_i,
	input  logic [dcache_pkg::ADR_W-1:0]        beat_adr_i,
	input  logic                                beat_we_i,
	input  logic [dcache_pkg::LINE_BYTES-1:0]   beat_sel_i,
	input  logic [dcache_pkg::LINE_W-1:0]       beat_dat_i,
	// Bus response
	input  logic                                bus_ack_i,
	input  logic                                bus_rty_i,
	input  logic [dcache_pkg::BEAT_IDX_W-1:0]   bus_tid_i,
	// Bus request
	output logic                                bus_cyc_o,
	output logic                                bus_we_o,
	output logic [dcache_pkg::ADR_W-1:0]        bus_adr_o,
	output logic [dcache_pkg::BEAT_BYTES-1:0]   bus_sel_o,
	output logic [dcache_pkg::BEAT_W-1:0]       bus_dat_o,
	output logic [dcache_pkg::BEAT_IDX_W-1:0]   bus_tid_o
);

	localparam int IW = dcache_pkg::BEAT_IDX_W;
	localparam int SUB_W = $clog2(dcache_pkg::BEAT_BYTES);

	dcache_pkg::iss_state_e state;

	logic [dcache_pkg::BEATS-1:0] pending;
	logic [dcache_pkg::BEATS-1:0] outstanding;
	logic [dcache_pkg::BEATS-1:0] ready;
	logic [IW-1:0] cur_idx;
	logic [IW-1:0] pick_idx;
	logic [CNT_W-1:0] wait_cnt;
	logic [16:0] lfsr;

	// Lowest pending beat that is not already on the bus
	assign ready = pending & ~outstanding;

	always_comb begin
		pick_idx = '0;
		for (int b = dcache_pkg::BEATS - 1; b >= 0; b--) begin
			if (ready[b]) begin
				pick_idx = IW'(b);
			end
		end
	end

	// The beat is addressed as line base plus index times the strip size
	assign bus_we_o = beat_we_i;
	assign bus_tid_o = cur_idx;
	assign bus_adr_o = {beat_adr_i[dcache_pkg::ADR_W-1:IW+SUB_W], cur_idx, {SUB_W{1'b0}}};
	assign bus_sel_o = beat_we_i ?
		beat_sel_i[cur_idx*dcache_pkg::BEAT_BYTES +: dcache_pkg::BEAT_BYTES] : '1;
	assign bus_dat_o = beat_dat_i[cur_idx*dcache_pkg::BEAT_W +: dcache_pkg::BEAT_W];

	// ====================================================================
	// Issue FSM
	// ====================================================================

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			state <= dcache_pkg::PICK;
			pending <= '0;
			outstanding <= '0;
			cur_idx <= '0;
			bus_cyc_o <= 1'b0;
			wait_cnt <= '0;
		end else begin
			if (start_i) begin
				pending <= beat_mask_i;
				outstanding <= '0;
			end
			case (state)
				dcache_pkg::PICK: begin
					if (|ready) begin
						cur_idx <= pick_idx;
						outstanding[pick_idx] <= 1'b1;
						bus_cyc_o <= 1'b1;
						state <= dcache_pkg::BUS_CYCLE;
					end
				end
				dcache_pkg::BUS_CYCLE: begin
					if (bus_ack_i) begin
						pending[bus_tid_i] <= 1'b0;
						outstanding[bus_tid_i] <= 1'b0;
						bus_cyc_o <= 1'b0;
						state <= dcache_pkg::GAP;
					end else if (bus_rty_i) begin
						// The beat stays pending and is picked again later
						outstanding[cur_idx] <= 1'b0;
						bus_cyc_o <= 1'b0;
						wait_cnt <= '0;
						state <= dcache_pkg::BACKOFF;
					end
				end
				dcache_pkg::GAP: begin
					state <= dcache_pkg::PICK;
				end
				dcache_pkg::BACKOFF: begin
					if (wait_cnt == CNT_W'(BACKOFF)) begin
						if (lfsr[2:0] == 3'b111) begin
							state <= dcache_pkg::PICK;
						end
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				default: state <= dcache_pkg::PICK;
			endcase
		end
	end

	// Free-running x^17 + x^14 + 1 sequence
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			lfsr <= 17'h1;
		end else begin
			lfsr <= {lfsr[15:0], lfsr[16] ^ lfsr[13]};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/dcache_ctrl.sv ====
// ====================================================================
// Data cache miss controller top level
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
	parameter int WAYS = 4,
	parameter int BACKOFF = 6,
	localparam int WAY_W = $clog2(WAYS)
) (
	input  logic                                clk_i,
	input  logic                                rst_i,
	// CPU side
	input  logic                                cpu_req_i,
	input  logic                                cpu_we_i,
	input  dcache_pkg::cache_kind_e             cpu_kind_i,
	input  logic [dcache_pkg::ADR_W-1:0]        cpu_adr_i,
	input  logic [dcache_pkg::LINE_BYTES-1:0]   cpu_sel_i,
	input  logic [dcache_pkg::LINE_W-1:0]       cpu_dat_i,
	output logic                                cpu_ack_o,
	output logic [dcache_pkg::LINE_W-1:0]       cpu_dat_o,
	// Cache side
	input  logic                                hit_i,
	input  logic [dcache_pkg::LINE_W-1:0]       hit_dat_i,
	input  logic [WAY_W-1:0]                    hit_way_i,
	output logic                                load_o,
	output logic                                wr_o,
	output logic [dcache_pkg::ADR_W-1:0]        load_adr_o,
	output logic [dcache_pkg::LINE_W-1:0]       load_dat_o,
	output logic [WAY_W-1:0]                    way_o,
	// Bus side
	output logic                                bus_cyc_o,
	output logic                                bus_we_o,
	output logic [dcache_pkg::ADR_W-1:0]        bus_adr_o,
	output logic [dcache_pkg::BEAT_BYTES-1:0]   bus_sel_o,
	output logic [dcache_pkg::BEAT_W-1:0]       bus_dat_o,
	output logic [dcache_pkg::BEAT_IDX_W-1:0]   bus_tid_o,
	input  logic                                bus_ack_i,
	input  logic                                bus_rty_i,
	input  logic [dcache_pkg::BEAT_IDX_W-1:0]   bus_tid_i,
	input  logic [dcache_pkg::BEAT_W-1:0]       bus_dat_i
);

	logic start;
	logic [dcache_pkg::BEATS-1:0] beat_mask;
	logic [dcache_pkg::ADR_W-1:0] beat_adr;
	logic beat_we;
	logic [dcache_pkg::LINE_BYTES-1:0] beat_sel;
	logic [dcache_pkg::LINE_W-1:0] beat_dat;
	logic [dcache_pkg::LINE_BYTES-1:0] merge_mask;
	logic line_done;
	logic [dcache_pkg::LINE_W-1:0] line_dat;

	miss_sequencer #(
		.WAYS(WAYS)
	) u_seq (
		.clk_i(clk_i), .rst_i(rst_i),
		.cpu_req_i(cpu_req_i), .cpu_we_i(cpu_we_i), .cpu_kind_i(cpu_kind_i),
		.cpu_adr_i(cpu_adr_i), .cpu_sel_i(cpu_sel_i), .cpu_dat_i(cpu_dat_i),
		.hit_i(hit_i), .hit_dat_i(hit_dat_i), .hit_way_i(hit_way_i),
		.line_done_i(line_done), .line_dat_i(line_dat),
		.cpu_ack_o(cpu_ack_o), .cpu_dat_o(cpu_dat_o),
		.load_o(load_o), .wr_o(wr_o), .load_adr_o(load_adr_o),
		.load_dat_o(load_dat_o), .way_o(way_o),
		.start_o(start), .beat_mask_o(beat_mask), .beat_adr_o(beat_adr),
		.beat_we_o(beat_we), .beat_sel_o(beat_sel), .beat_dat_o(beat_dat),
		.merge_mask_o(merge_mask)
	);

	beat_issuer #(
		.BACKOFF(BACKOFF)
	) u_iss (
		.clk_i(clk_i), .rst_i(rst_i),
		.start_i(start), .beat_mask_i(beat_mask), .beat_adr_i(beat_adr),
		.beat_we_i(beat_we), .beat_sel_i(beat_sel), .beat_dat_i(beat_dat),
		.bus_ack_i(bus_ack_i), .bus_rty_i(bus_rty_i), .bus_tid_i(bus_tid_i),
		.bus_cyc_o(bus_cyc_o), .bus_we_o(bus_we_o), .bus_adr_o(bus_adr_o),
		.bus_sel_o(bus_sel_o), .bus_dat_o(bus_dat_o), .bus_tid_o(bus_tid_o)
	);

	// The hit line seeds the assembler so a write-through hit merges onto it
	line_assembler u_asm (
		.clk_i(clk_i), .rst_i(rst_i),
		.start_i(start), .beat_mask_i(beat_mask),
		.merge_mask_i(merge_mask), .merge_dat_i(beat_dat),
		.base_dat_i(hit_dat_i),
		.bus_ack_i(bus_ack_i), .bus_tid_i(bus_tid_i), .bus_dat_i(bus_dat_i),
		.beat_we_i(beat_we),
		.line_done_o(line_done), .line_dat_o(line_dat)
	);

endmodule

`default_nettype wire

// ==== hdl/dcache_pkg.sv ====
// ====================================================================
// Shared widths, cache kinds and FSM state encodings for the data
// cache miss controller
// ====================================================================
`default_nettype none

package dcache_pkg;

	// ====================================================================
	// Widths
	// ====================================================================

	// Byte address of a request
	localparam int ADR_W = 32;

	// One cache line and one bus beat
	localparam int LINE_W = 512;
	localparam int BEAT_W = 128;
	localparam int BEATS = LINE_W / BEAT_W;
	localparam int LINE_BYTES = LINE_W / 8;
	localparam int BEAT_BYTES = BEAT_W / 8;

	// Beat index, also used as the bus tag
	localparam int BEAT_IDX_W = $clog2(BEATS);

	// ====================================================================
	// Encodings
	// ====================================================================

	typedef enum logic [1:0] {
		NON_CACHEABLE = 2'd0,
		WRITE_THROUGH = 2'd1,
		WRITE_BACK    = 2'd2
	} cache_kind_e;

	// Request sequencing, one CPU request in flight
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		ISSUE     = 2'd1,
		WAIT_LINE = 2'd2,
		FINISH    = 2'd3
	} seq_state_e;

	// Bus beat issue with retry backoff
	typedef enum logic [1:0] {
		PICK      = 2'd0,
		BUS_CYCLE = 2'd1,
		GAP       = 2'd2,
		BACKOFF   = 2'd3
	} iss_state_e;

endpackage

`default_nettype wire

// ==== hdl/line_assembler.sv ====
// ====================================================================
// Line assembler: collects acked beats and merges the write bytes
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module line_assembler (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  logic                                start_i,
	input  logic [dcache_pkg::BEATS-1:0]        beat_mask_i,
	input  logic [dcache_pkg::LINE_BYTES-1:0]   merge_mask_i,
	input  logic [dcache_pkg::LINE_W-1:0]       merge_dat_i,
	input  logic [dcache_pkg::LINE_W-1:0]       base_dat_i,
	input  logic                                bus_ack_i,
	input  logic [dcache_pkg::BEAT_IDX_W-1:0]   bus_tid_i,
	input  logic [dcache_pkg::BEAT_W-1:0]       bus_dat_i,
	input  logic                                beat_we_i,
	output logic                                line_done_o,
	output logic [dcache_pkg::LINE_W-1:0]       line_dat_o
);

	logic busy;
	logic all_done;
	logic [dcache_pkg::BEATS-1:0] mask_r;
	logic [dcache_pkg::BEATS-1:0] done_r;
	logic [dcache_pkg::LINE_W-1:0] line_r;
	logic [dcache_pkg::LINE_W-1:0] merged;

	assign all_done = busy && ((done_r & mask_r) == mask_r);
	assign line_dat_o = line_r;

	always_comb begin
		for (int n = 0; n < dcache_pkg::LINE_BYTES; n++) begin
			merged[n*8 +: 8] = merge_mask_i[n] ? merge_dat_i[n*8 +: 8] : line_r[n*8 +: 8];
		end
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			busy <= 1'b0;
			mask_r <= '0;
			done_r <= '0;
			line_done_o <= 1'b0;
		end else begin
			line_done_o <= 1'b0;
			if (start_i) begin
				busy <= 1'b1;
				mask_r <= beat_mask_i;
				done_r <= '0;
			end else if (busy) begin
				if (bus_ack_i) begin
					done_r[bus_tid_i] <= 1'b1;
				end
				if (all_done) begin
					busy <= 1'b0;
					line_done_o <= 1'b1;
				end
			end
		end
	end

	// Stores keep the hit line as the base, loads start from an empty line
	always_ff @(posedge clk_i) begin
		if (start_i) begin
			line_r <= beat_we_i ? base_dat_i : '0;
		end else if (busy) begin
			if (bus_ack_i && !beat_we_i) begin
				line_r[bus_tid_i*dcache_pkg::BEAT_W +: dcache_pkg::BEAT_W] <= bus_dat_i;
			end
			if (all_done) begin
				line_r <= merged;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/miss_sequencer.sv ====
// ====================================================================
// Miss sequencer: request decode, beat planning, CPU answer and
// cache write/load outputs with round-robin way selection
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module miss_sequencer #(
	parameter int WAYS = 4,
	localparam int WAY_W = $clog2(WAYS)
) (
	input  logic                                clk_i,
	input  logic                                rst_i,
	// CPU request
	input  logic                                cpu_req_i,
	input  logic                                cpu_we_i,
	input  dcache_pkg::cache_kind_e             cpu_kind_i,
	input  logic [dcache_pkg::ADR_W-1:0]        cpu_adr_i,
	input  logic [dcache_pkg::LINE_BYTES-1:0]   cpu_sel_i,
	input  logic [dcache_pkg::LINE_W-1:0]       cpu_dat_i,
	// Cache lookup result for the request
	input  logic                                hit_i,
	input  logic [dcache_pkg::LINE_W-1:0]       hit_dat_i,
	input  logic [WAY_W-1:0]                    hit_way_i,
	// Assembled line
	input  logic                                line_done_i,
	input  logic [dcache_pkg::LINE_W-1:0]       line_dat_i,
	// CPU answer
	output logic                                cpu_ack_o,
	output logic [dcache_pkg::LINE_W-1:0]       cpu_dat_o,
	// Cache update
	output logic                                load_o,
	output logic                                wr_o,
	output logic [dcache_pkg::ADR_W-1:0]        load_adr_o,
	output logic [dcache_pkg::LINE_W-1:0]       load_dat_o,
	output logic [WAY_W-1:0]                    way_o,
	// Beat plan for the issuer and the assembler
	output logic                                start_o,
	output logic [dcache_pkg::BEATS-1:0]        beat_mask_o,
	output logic [dcache_pkg::ADR_W-1:0]        beat_adr_o,
	output logic                                beat_we_o,
	output logic [dcache_pkg::LINE_BYTES-1:0]   beat_sel_o,
	output logic [dcache_pkg::LINE_W-1:0]       beat_dat_o,
	output logic [dcache_pkg::LINE_BYTES-1:0]   merge_mask_o
);

	localparam int OFS_W = $clog2(dcache_pkg::LINE_BYTES);
	localparam int SB = dcache_pkg::BEAT_BYTES;

	dcache_pkg::seq_state_e state;

	// Latched request
	logic [dcache_pkg::ADR_W-1:0] req_adr;
	logic req_we;
	logic [dcache_pkg::LINE_BYTES-1:0] req_sel;
	logic [dcache_pkg::LINE_W-1:0] req_dat;
	dcache_pkg::cache_kind_e req_kind;
	logic req_hit;
	logic [WAY_W-1:0] req_way;

	logic [WAY_W-1:0] rr_way;
	logic hit_wr;
	logic [dcache_pkg::LINE_W-1:0] hit_wr_dat;
	logic [dcache_pkg::LINE_W-1:0] hit_merged;

	// Current request view: live inputs while idle, latched copy after
	logic in_idle;
	logic c_we;
	logic c_hit;
	logic [dcache_pkg::ADR_W-1:0] c_adr;
	logic [dcache_pkg::LINE_BYTES-1:0] c_sel;
	logic [dcache_pkg::LINE_W-1:0] c_dat;
	dcache_pkg::cache_kind_e c_kind;
	logic c_line;
	logic c_fast;
	logic c_wt_hit;
	logic [dcache_pkg::BEATS-1:0] strip_mask;

	assign in_idle = (state == dcache_pkg::IDLE);
	assign c_we = in_idle ? cpu_we_i : req_we;
	assign c_hit = in_idle ? hit_i : req_hit;
	assign c_adr = in_idle ? cpu_adr_i : req_adr;
	assign c_sel = in_idle ? cpu_sel_i : req_sel;
	assign c_dat = in_idle ? cpu_dat_i : req_dat;
	assign c_kind = in_idle ? cpu_kind_i : req_kind;

	// A cacheable miss fetches the whole line, except a write-through write
	assign c_line = (c_kind != dcache_pkg::NON_CACHEABLE) && !c_hit &&
		(!c_we || c_kind == dcache_pkg::WRITE_BACK);
	// Read hits and write-back write hits never touch the bus
	assign c_fast = (c_kind != dcache_pkg::NON_CACHEABLE) && c_hit &&
		(!c_we || c_kind == dcache_pkg::WRITE_BACK);
	assign c_wt_hit = (c_kind == dcache_pkg::WRITE_THROUGH) && c_we && c_hit;

	always_comb begin
		for (int b = 0; b < dcache_pkg::BEATS; b++) begin
			strip_mask[b] = |c_sel[b*SB +: SB];
		end
	end

	always_comb begin
		for (int n = 0; n < dcache_pkg::LINE_BYTES; n++) begin
			hit_merged[n*8 +: 8] = cpu_sel_i[n] ? cpu_dat_i[n*8 +: 8] : hit_dat_i[n*8 +: 8];
		end
	end

	// ====================================================================
	// Beat plan
	// ====================================================================

	assign start_o = cpu_req_i && in_idle && !c_fast;
	assign beat_mask_o = c_line ? {dcache_pkg::BEATS{1'b1}} : strip_mask;
	assign beat_adr_o = {c_adr[dcache_pkg::ADR_W-1:OFS_W], {OFS_W{1'b0}}};
	assign beat_we_o = c_line ? 1'b0 : c_we;
	assign beat_sel_o = c_sel;
	assign beat_dat_o = c_dat;
	assign merge_mask_o = c_we ? c_sel : '0;

	// ====================================================================
	// CPU and cache outputs
	// ====================================================================

	assign cpu_ack_o = (cpu_req_i && in_idle && c_fast) || (state == dcache_pkg::FINISH);
	assign cpu_dat_o = (state == dcache_pkg::FINISH) ? line_dat_i : hit_dat_i;
	assign load_o = (state == dcache_pkg::FINISH) && c_line;
	assign wr_o = hit_wr || ((state == dcache_pkg::FINISH) && c_wt_hit);
	assign load_adr_o = {req_adr[dcache_pkg::ADR_W-1:OFS_W], {OFS_W{1'b0}}};
	assign load_dat_o = hit_wr ? hit_wr_dat : line_dat_i;
	// A rewrite goes back to the way that hit, a load to the next round-robin way
	assign way_o = wr_o ? req_way : rr_way;

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			state <= dcache_pkg::IDLE;
			rr_way <= '0;
			hit_wr <= 1'b0;
		end else begin
			hit_wr <= 1'b0;
			case (state)
				dcache_pkg::IDLE: begin
					if (start_o) begin
						state <= dcache_pkg::ISSUE;
					end
					if (cpu_req_i && c_fast && cpu_we_i) begin
						hit_wr <= 1'b1;
					end
				end
				dcache_pkg::ISSUE: begin
					state <= line_done_i ? dcache_pkg::FINISH : dcache_pkg::WAIT_LINE;
				end
				dcache_pkg::WAIT_LINE: begin
					if (line_done_i) begin
						state <= dcache_pkg::FINISH;
					end
				end
				dcache_pkg::FINISH: begin
					state <= dcache_pkg::IDLE;
					if (load_o) begin
						rr_way <= (rr_way == WAY_W'(WAYS - 1)) ? '0 : rr_way + 1'b1;
					end
				end
				default: state <= dcache_pkg::IDLE;
			endcase
		end
	end

	// Request payload, captured with each accepted request
	always_ff @(posedge clk_i) begin
		if (cpu_req_i && in_idle) begin
			req_adr <= cpu_adr_i;
			req_we <= cpu_we_i;
			req_sel <= cpu_sel_i;
			req_dat <= cpu_dat_i;
			req_kind <= cpu_kind_i;
			req_hit <= hit_i;
			req_way <= hit_way_i;
			hit_wr_dat <= hit_merged;
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/dcache_pkg.sv
hdl/miss_sequencer.sv
hdl/beat_issuer.sv
hdl/line_assembler.sv
hdl/dcache_ctrl.sv
testbench/bus_responder.sv
testbench/tb_dcache_ctrl.sv

// ==== testbench/bus_responder.sv ====
// ====================================================================
// Bus memory model with random retries and a store log
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module bus_responder (
	input  logic          clk_i,
	input  logic          cyc_i,
	input  logic          we_i,
	input  logic [31:0]   adr_i,
	input  logic [15:0]   sel_i,
	input  logic [127:0]  dat_i,
	input  logic [1:0]    tid_i,
	output logic          ack_o,
	output logic          rty_o,
	output logic [1:0]    tid_o,
	output logic [127:0]  dat_o
);

	localparam int LOG_DEPTH = 256;

	integer seed = 87;
	logic active;
	int wait_left;

	// Store log, read by the testbench through the instance
	int store_cnt;
	int rty_cnt;
	logic [31:0] store_adr [LOG_DEPTH];
	logic [15:0] store_sel [LOG_DEPTH];
	logic [127:0] store_dat [LOG_DEPTH];

	// Responses change 2 ns after the rising edge, like every other input
	initial begin
		ack_o = 1'b0;
		rty_o = 1'b0;
		tid_o = '0;
		dat_o = '0;
		active = 1'b0;
		wait_left = 0;
		store_cnt = 0;
		rty_cnt = 0;
		forever begin
			@(posedge clk_i);
			#2;
			ack_o = 1'b0;
			rty_o = 1'b0;
			if (cyc_i && !active) begin
				active = 1'b1;
				wait_left = $unsigned($random(seed)) % 3;
			end
			if (active) begin
				if (wait_left > 0) begin
					wait_left--;
				end else begin
					active = 1'b0;
					tid_o = tid_i;
					if (($random(seed) & 3) == 0) begin
						rty_o = 1'b1;
						rty_cnt++;
					end else begin
						ack_o = 1'b1;
						if (we_i) begin
							if (store_cnt < LOG_DEPTH) begin
								store_adr[store_cnt] = adr_i;
								store_sel[store_cnt] = sel_i;
								store_dat[store_cnt] = dat_i;
							end
							store_cnt++;
						end else begin
							// Every 32-bit word holds its own word address
							for (int k = 0; k < 4; k++) begin
								dat_o[32*k +: 32] = (adr_i >> 2) + k;
							end
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_dcache_ctrl.sv ====
// ====================================================================
// Testbench for the data cache miss controller with stimulus, expected
// line model, checks, watchdog and report
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_ctrl;

	localparam int WAYS = 4;
	localparam int BACKOFF = 6;
	localparam int WAY_W = $clog2(WAYS);
	localparam int LW = dcache_pkg::LINE_W;
	localparam int LB = dcache_pkg::LINE_BYTES;
	// Three rounds of eight requests with up to four beats each and ample room for retries
	localparam int MAX_CYCLES = 4000;

	logic clk_i;
	logic rst_i;
	logic cpu_req;
	logic cpu_we;
	dcache_pkg::cache_kind_e cpu_kind;
	logic [31:0] cpu_adr;
	logic [LB-1:0] cpu_sel;
	logic [LW-1:0] cpu_dat;
	logic cpu_ack;
	logic [LW-1:0] cpu_rdat;
	logic hit;
	logic [LW-1:0] hit_dat;
	logic [WAY_W-1:0] hit_way;
	logic load;
	logic wr;
	logic [31:0] load_adr;
	logic [LW-1:0] load_dat;
	logic [WAY_W-1:0] way;
	logic bus_cyc;
	logic bus_we;
	logic [31:0] bus_adr;
	logic [15:0] bus_sel;
	logic [127:0] bus_wdat;
	logic [1:0] bus_tid;
	logic bus_ack;
	logic bus_rty;
	logic [1:0] bus_rtid;
	logic [127:0] bus_rdat;

	integer seed = 87;
	int errors;
	int checks;
	int cycles;
	int exp_way;

	// Observations of the last request
	int ack_cycle;
	logic [LW-1:0] ack_line;
	int n_loads;
	int n_wrs;
	logic [LW-1:0] upd_dat;
	logic [31:0] upd_adr;
	logic [WAY_W-1:0] upd_way;
	logic upd_with_ack;
	logic [3:0] strips_seen;
	logic cyc_seen;

	dcache_ctrl #(
		.WAYS(WAYS),
		.BACKOFF(BACKOFF)
	) uut (
		.clk_i(clk_i), .rst_i(rst_i),
		.cpu_req_i(cpu_req), .cpu_we_i(cpu_we), .cpu_kind_i(cpu_kind),
		.cpu_adr_i(cpu_adr), .cpu_sel_i(cpu_sel), .cpu_dat_i(cpu_dat),
		.cpu_ack_o(cpu_ack), .cpu_dat_o(cpu_rdat),
		.hit_i(hit), .hit_dat_i(hit_dat), .hit_way_i(hit_way),
		.load_o(load), .wr_o(wr), .load_adr_o(load_adr), .load_dat_o(load_dat), .way_o(way),
		.bus_cyc_o(bus_cyc), .bus_we_o(bus_we), .bus_adr_o(bus_adr), .bus_sel_o(bus_sel),
		.bus_dat_o(bus_wdat), .bus_tid_o(bus_tid),
		.bus_ack_i(bus_ack), .bus_rty_i(bus_rty), .bus_tid_i(bus_rtid), .bus_dat_i(bus_rdat)
	);

	bus_responder responder (
		.clk_i(clk_i), .cyc_i(bus_cyc), .we_i(bus_we), .adr_i(bus_adr), .sel_i(bus_sel),
		.dat_i(bus_wdat), .tid_i(bus_tid),
		.ack_o(bus_ack), .rty_o(bus_rty), .tid_o(bus_rtid), .dat_o(bus_rdat)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	// ====================================================================
	// Expected-value model and helpers
	// ====================================================================

	task automatic verify(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s", $time, what);
		end
	endtask

	function automatic logic [LW-1:0] pattern_line(input logic [31:0] base);
		logic [LW-1:0] l;
		for (int w = 0; w < LW / 32; w++) begin
			l[32*w +: 32] = (base >> 2) + w;
		end
		return l;
	endfunction

	function automatic logic [LW-1:0] line_mask(input logic [LB-1:0] bytes);
		logic [LW-1:0] m;
		for (int n = 0; n < LB; n++) begin
			m[8*n +: 8] = {8{bytes[n]}};
		end
		return m;
	endfunction

	function automatic logic [LW-1:0] merge_line(input logic [LW-1:0] base,
			input logic [LB-1:0] sel, input logic [LW-1:0] dat);
		logic [LW-1:0] m;
		m = line_mask(sel);
		return (base & ~m) | (dat & m);
	endfunction

	function automatic logic [LW-1:0] rand_line();
		logic [LW-1:0] l;
		for (int k = 0; k < LW / 32; k++) begin
			l[32*k +: 32] = $random(seed);
		end
		return l;
	endfunction

	function automatic logic [31:0] rand_base();
		return {$random(seed)} & 32'hFFFF_FFC0;
	endfunction

	// Byte selects confined to a random, non-empty set of strips
	task automatic make_sel(output logic [LB-1:0] sel, output logic [3:0] strips);
		logic [15:0] part;
		strips = 4'($random(seed));
		if (strips == 4'b0000) begin
			strips = 4'b0101;
		end
		for (int i = 0; i < 4; i++) begin
			part = 16'($random(seed));
			if (part == 16'h0000) begin
				part = 16'h8000;
			end
			sel[16*i +: 16] = strips[i] ? part : 16'h0000;
		end
	endtask

	task automatic note_update();
		if (load || wr) begin
			n_loads += int'(load);
			n_wrs += int'(wr);
			upd_dat = load_dat;
			upd_adr = load_adr;
			upd_way = way;
			upd_with_ack = cpu_ack;
		end
	endtask

	// ====================================================================
	// Request driver and monitor
	// ====================================================================

	task automatic run_request(input logic we, input dcache_pkg::cache_kind_e kind,
			input logic [31:0] adr, input logic [LB-1:0] sel, input logic [LW-1:0] dat,
			input logic h, input logic [LW-1:0] hd, input logic [WAY_W-1:0] hw);
		logic [3:0] acked;
		logic done;
		int n;
		acked = '0;
		done = 1'b0;
		n = 0;
		n_loads = 0;
		n_wrs = 0;
		ack_cycle = -1;
		upd_with_ack = 1'b0;
		strips_seen = '0;
		cyc_seen = 1'b0;
		@(posedge clk_i);
		#2;
		cpu_req = 1'b1;
		cpu_we = we;
		cpu_kind = kind;
		cpu_adr = adr;
		cpu_sel = sel;
		cpu_dat = dat;
		hit = h;
		hit_dat = hd;
		hit_way = hw;
		while (!done) begin
			@(negedge clk_i);
			if (bus_cyc) begin
				cyc_seen = 1'b1;
				strips_seen[bus_adr[5:4]] = 1'b1;
			end
			if (bus_ack) begin
				verify(!acked[bus_rtid], "beat acked twice");
				acked[bus_rtid] = 1'b1;
				verify(bus_adr[5:4] == bus_tid, "bus tag does not match the beat address");
				verify(bus_adr[31:6] == adr[31:6], "bus address outside the requested line");
			end
			note_update();
			if (cpu_ack) begin
				done = 1'b1;
				ack_cycle = n;
				ack_line = cpu_rdat;
			end
			@(posedge clk_i);
			#2;
			cpu_req = 1'b0;
			n++;
		end
		// A write-back hit rewrites the cache in the cycle after its ack
		// and a fast request must leave the bus idle in the cycles that follow
		repeat (3) begin
			@(negedge clk_i);
			note_update();
			if (bus_cyc) begin
				cyc_seen = 1'b1;
			end
		end
	endtask

	// ====================================================================
	// Behaviors
	// ====================================================================

	task automatic test_read_hit();
		logic [LW-1:0] hd;
		hd = rand_line();
		run_request(1'b0, dcache_pkg::WRITE_BACK, rand_base(), '0, '0, 1'b1, hd, 2'd1);
		verify(ack_cycle == 0, "read hit not acked in the request cycle");
		verify(ack_line == hd, "read hit returned wrong data");
		verify(!cyc_seen && n_loads == 0 && n_wrs == 0, "read hit used the bus or the cache");
	endtask

	task automatic test_read_miss(input dcache_pkg::cache_kind_e kind);
		logic [31:0] base;
		base = rand_base();
		run_request(1'b0, kind, base | ({$random(seed)} & 32'h3C), '0, '0, 1'b0,
			rand_line(), 2'd0);
		verify(n_loads == 1 && n_wrs == 0, "read miss did not load the line once");
		verify(upd_dat == pattern_line(base), "loaded line differs from memory");
		verify(upd_adr == base, "load address is not the line base");
		verify(upd_way == WAY_W'(exp_way), "load went to the wrong way");
		verify(upd_with_ack && ack_line == upd_dat, "CPU data and load do not match");
		verify(strips_seen == 4'hF, "read miss did not fetch all four beats");
		exp_way = (exp_way + 1) % WAYS;
	endtask

	task automatic test_wb_write_miss();
		logic [31:0] base;
		logic [LB-1:0] sel;
		logic [LW-1:0] dat;
		int first;
		base = rand_base();
		sel = {$random(seed), $random(seed)};
		dat = rand_line();
		first = responder.store_cnt;
		run_request(1'b1, dcache_pkg::WRITE_BACK, base, sel, dat, 1'b0, rand_line(), 2'd0);
		verify(n_loads == 1 && n_wrs == 0, "write-back miss did not load the line once");
		verify(upd_dat == merge_line(pattern_line(base), sel, dat),
			"write-back miss loaded a wrongly merged line");
		verify(upd_way == WAY_W'(exp_way), "load went to the wrong way");
		verify(responder.store_cnt == first, "write-back miss issued store beats");
		exp_way = (exp_way + 1) % WAYS;
	endtask

	task automatic check_stores(input int first, input logic [31:0] base,
			input logic [LB-1:0] sel, input logic [LW-1:0] dat);
		logic [LW-1:0] smask;
		int k;
		k = first;
		for (int i = 0; i < 4; i++) begin
			if (|sel[16*i +: 16]) begin
				smask = line_mask({48'b0, sel[16*i +: 16]});
				verify(k < responder.store_cnt, "store beat missing");
				if (k < responder.store_cnt) begin
					verify(responder.store_adr[k] == base + 16 * i, "store at wrong address");
					verify(responder.store_sel[k] == sel[16*i +: 16], "store with wrong select");
					verify((responder.store_dat[k] & smask[127:0]) ==
						(dat[128*i +: 128] & smask[127:0]), "store with wrong data");
				end
				k++;
			end
		end
		verify(responder.store_cnt == k, "extra store beats on the bus");
	endtask

	task automatic test_wt_write(input logic h);
		logic [31:0] base;
		logic [LB-1:0] sel;
		logic [3:0] strips;
		logic [LW-1:0] dat;
		logic [LW-1:0] hd;
		int first;
		base = rand_base();
		make_sel(sel, strips);
		dat = rand_line();
		hd = rand_line();
		first = responder.store_cnt;
		run_request(1'b1, dcache_pkg::WRITE_THROUGH, base, sel, dat, h, hd, 2'd3);
		check_stores(first, base, sel, dat);
		verify(n_loads == 0, "write-through write loaded a line");
		if (h) begin
			verify(n_wrs == 1 && upd_with_ack, "write-through hit did not rewrite the line");
			verify(upd_dat == merge_line(hd, sel, dat) && upd_way == 2'd3,
				"write-through hit rewrote wrong data or way");
		end else begin
			verify(n_wrs == 0, "write-through miss wrote the cache");
		end
	endtask

	task automatic test_nc_read();
		logic [31:0] base;
		logic [LB-1:0] sel;
		logic [3:0] strips;
		logic [LW-1:0] keep;
		base = rand_base();
		make_sel(sel, strips);
		keep = line_mask({{16{strips[3]}}, {16{strips[2]}}, {16{strips[1]}}, {16{strips[0]}}});
		run_request(1'b0, dcache_pkg::NON_CACHEABLE, base, sel, '0, 1'b0, rand_line(), 2'd0);
		verify(strips_seen == strips, "non-cacheable read fetched unselected strips");
		verify(ack_line == (pattern_line(base) & keep), "non-cacheable read data wrong");
		verify(n_loads == 0 && n_wrs == 0, "non-cacheable read touched the cache");
	endtask

	task automatic test_wb_write_hit();
		logic [LB-1:0] sel;
		logic [LW-1:0] dat;
		logic [LW-1:0] hd;
		sel = {$random(seed), $random(seed)};
		dat = rand_line();
		hd = rand_line();
		run_request(1'b1, dcache_pkg::WRITE_BACK, rand_base(), sel, dat, 1'b1, hd, 2'd2);
		verify(ack_cycle == 0 && !cyc_seen, "write-back hit was not answered at once");
		verify(n_wrs == 1 && n_loads == 0 && !upd_with_ack,
			"write-back hit did not rewrite the line once after its ack");
		verify(upd_dat == merge_line(hd, sel, dat) && upd_way == 2'd2,
			"write-back hit rewrote wrong data or way");
	endtask

	// ====================================================================
	// Main sequence and watchdog
	// ====================================================================

	initial begin
		rst_i = 1'b1;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_kind = dcache_pkg::NON_CACHEABLE;
		cpu_adr = '0;
		cpu_sel = '0;
		cpu_dat = '0;
		hit = 1'b0;
		hit_dat = '0;
		hit_way = '0;
		errors = 0;
		checks = 0;
		exp_way = 0;
		repeat (8) @(posedge clk_i);
		#2;
		rst_i = 1'b0;
		verify(!cpu_ack && !load && !wr && !bus_cyc && way == '0, "outputs not idle after reset");
		repeat (3) begin
			test_read_hit();
			test_read_miss(dcache_pkg::WRITE_BACK);
			test_read_miss(dcache_pkg::WRITE_THROUGH);
			test_wb_write_miss();
			test_wt_write(1'b1);
			test_wt_write(1'b0);
			test_nc_read();
			test_wb_write_hit();
		end
		repeat (4) @(posedge clk_i);
		verify(responder.rty_cnt > 0, "no retry was injected");
		$display("Checks: %0d, errors: %0d, retries: %0d", checks, errors, responder.rty_cnt);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Checks: %0d, errors: %0d, retries: %0d", checks, errors, responder.rty_cnt);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
